// File: vlog.f
+incdir+src
src/pix_pkg.sv
src/cam_sampler.sv
src/pixel_fifo.sv
src/rgb_logic.sv
src/block_stats.sv
src/rgb_capture_top.sv
tests/tb_rgb_capture.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_rgb_capture
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_rgb_capture.sv
`timescale 1ns/100ps

`include "pix_macros.svh"

module tb_rgb_capture;
    import pix_pkg::*;

    localparam int FRAME_W = `PIX_BLOCK_W * `PIX_BLOCK_COLS;
    localparam int FRAME_H = `PIX_BLOCK_H * `PIX_BLOCK_LINES;
    // vsync low word, two lead-in words, one blank word per line
    localparam int FRAME_WORDS = 3 + FRAME_H * (FRAME_W + 1);
    localparam int PARTIAL_WORDS = 100;
    localparam int NUM_FRAMES = 4;
    localparam int CYCLE_LIMIT = 4 * (PARTIAL_WORDS + NUM_FRAMES * FRAME_WORDS) + 1000;

    logic        clk;
    logic        nrst;
    rgb_t        cam_rgb;
    logic        cam_hsync;
    logic        cam_vsync;
    logic        cam_strobe;
    logic        rgb_enable;
    rgb_t        pixel_data;
    logic [31:0] pixel_idx;
    logic        pixel_valid;
    logic        sum_valid;
    block_sum_t  sum_value;
    logic [2:0]  sum_block_col;
    logic [1:0]  sum_block_line;
    logic        overflow;

    integer      seed;
    int          cycle_count = 0;
    rgb_t        frame_pix [FRAME_H][FRAME_W];

    rgb_t        exp_pix_q [$];
    logic [31:0] exp_idx_q [$];
    block_sum_t  exp_sum_q [$];
    logic [2:0]  exp_bcol_q [$];
    logic [1:0]  exp_bline_q [$];

    rgb_capture_top rgb_capture_top_i (
        .clk            (clk),
        .nrst           (nrst),
        .cam_rgb        (cam_rgb),
        .cam_hsync      (cam_hsync),
        .cam_vsync      (cam_vsync),
        .cam_strobe     (cam_strobe),
        .rgb_enable     (rgb_enable),
        .pixel_data     (pixel_data),
        .pixel_idx      (pixel_idx),
        .pixel_valid    (pixel_valid),
        .sum_valid      (sum_valid),
        .sum_value      (sum_value),
        .sum_block_col  (sum_block_col),
        .sum_block_line (sum_block_line),
        .overflow       (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout after %0d cycles, outputs never drained", cycle_count));
        end
    end

    task automatic check_pixel(input rgb_t exp_rgb, input logic [31:0] exp_idx);
        if (pixel_data !== exp_rgb) begin
            fail_run($sformatf("[ERROR] %0t pixel_data expected %h actual %h",
                               $time, exp_rgb, pixel_data));
        end
        if (pixel_idx !== exp_idx) begin
            fail_run($sformatf("[ERROR] %0t pixel_idx expected %0d actual %0d",
                               $time, exp_idx, pixel_idx));
        end
    endtask

    task automatic check_sum(input block_sum_t exp_sum, input logic [2:0] exp_col,
                             input logic [1:0] exp_line);
        if (sum_value !== exp_sum) begin
            fail_run($sformatf("[ERROR] %0t sum_value expected %0d actual %0d",
                               $time, exp_sum, sum_value));
        end
        if (sum_block_col !== exp_col) begin
            fail_run($sformatf("[ERROR] %0t sum_block_col expected %0d actual %0d",
                               $time, exp_col, sum_block_col));
        end
        if (sum_block_line !== exp_line) begin
            fail_run($sformatf("[ERROR] %0t sum_block_line expected %0d actual %0d",
                               $time, exp_line, sum_block_line));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            fail_run($sformatf("[ERROR] %0t %s expected %b actual %b",
                               $time, name, exp_val, act_val));
        end
    endtask

    // Green total of one micro-block of the stored frame
    function automatic block_sum_t green_sum(input int bl, input int bc);
        int total;
        total = 0;
        for (int y = 0; y < `PIX_BLOCK_H; y++) begin
            for (int x = 0; x < `PIX_BLOCK_W; x++) begin
                total += int'(frame_pix[bl * `PIX_BLOCK_H + y][bc * `PIX_BLOCK_W + x].green);
            end
        end
        return block_sum_t'(total);
    endfunction

    function automatic rgb_t random_rgb();
        logic [31:0] r;
        r = $random(seed);
        return r[23:0];
    endfunction

    // One strobed word, then a random idle gap unless bursting
    task automatic send_word(input rgb_t value, input logic hs, input logic vs,
                             input logic burst);
        int gap;
        gap = burst ? 0 : int'($unsigned($random(seed)) % 3);
        @(posedge clk);
        cam_rgb <= value;
        cam_hsync <= hs;
        cam_vsync <= vs;
        cam_strobe <= 1'b1;
        repeat (gap) begin
            @(posedge clk);
            cam_strobe <= 1'b0;
        end
    endtask

    task automatic send_frame(input logic enabled, input logic burst, input logic raise_mid);
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                frame_pix[y][x] = random_rgb();
            end
        end
        if (enabled) begin
            for (int y = 0; y < FRAME_H; y++) begin
                for (int x = 0; x < FRAME_W; x++) begin
                    exp_pix_q.push_back(frame_pix[y][x]);
                    exp_idx_q.push_back(32'(y * FRAME_W + x + 1));
                end
            end
            // Blocks finish in row-major order
            for (int bl = 0; bl < `PIX_BLOCK_LINES; bl++) begin
                for (int bc = 0; bc < `PIX_BLOCK_COLS; bc++) begin
                    exp_sum_q.push_back(green_sum(bl, bc));
                    exp_bcol_q.push_back(3'(bc));
                    exp_bline_q.push_back(2'(bl));
                end
            end
        end
        send_word(random_rgb(), 1'b0, 1'b0, burst);
        send_word(random_rgb(), 1'b0, 1'b1, burst);
        send_word(random_rgb(), 1'b0, 1'b1, burst);
        for (int y = 0; y < FRAME_H; y++) begin
            // Too late for this frame, enable is taken at the frame start
            if (raise_mid && y == FRAME_H / 2) begin
                rgb_enable <= 1'b1;
            end
            for (int x = 0; x < FRAME_W; x++) begin
                send_word(frame_pix[y][x], 1'b1, 1'b1, burst);
            end
            send_word(random_rgb(), 1'b0, 1'b1, burst);
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        rgb_t        exp_rgb;
        logic [31:0] exp_idx;
        block_sum_t  exp_sum;
        logic [2:0]  exp_col;
        logic [1:0]  exp_line;
        if (nrst) begin
            // FIFO drains a word every cycle, so even a burst never fills it
            check_flag("overflow", 1'b0, overflow);
            if (pixel_valid) begin
                if (exp_pix_q.size() == 0) begin
                    fail_run("pixel_valid went high while no pixel was expected");
                end else begin
                    exp_rgb = exp_pix_q.pop_front();
                    exp_idx = exp_idx_q.pop_front();
                    check_pixel(exp_rgb, exp_idx);
                end
            end
            if (sum_valid) begin
                if (exp_sum_q.size() == 0) begin
                    fail_run("sum_valid went high while no block sum was expected");
                end else begin
                    exp_sum = exp_sum_q.pop_front();
                    exp_col = exp_bcol_q.pop_front();
                    exp_line = exp_bline_q.pop_front();
                    check_sum(exp_sum, exp_col, exp_line);
                end
            end
        end
    end

    initial begin
        seed = 10872;
        nrst = 1'b0;
        cam_rgb = '0;
        cam_hsync = 1'b0;
        cam_vsync = 1'b0;
        cam_strobe = 1'b0;
        rgb_enable = 1'b1;
        repeat (10) @(posedge clk);
        nrst <= 1'b1;

        // Tail of a frame already running at reset
        for (int i = 0; i < PARTIAL_WORDS; i++) begin
            send_word(random_rgb(), 1'b1, 1'b1, 1'b0);
        end
        send_frame(1'b1, 1'b0, 1'b0);
        send_frame(1'b1, 1'b0, 1'b0);
        rgb_enable <= 1'b0;
        send_frame(1'b0, 1'b0, 1'b1);
        // Back-to-back strobes for a whole frame
        send_frame(1'b1, 1'b1, 1'b0);
        @(posedge clk);
        cam_strobe <= 1'b0;

        while (exp_pix_q.size() != 0 || exp_sum_q.size() != 0) begin
            @(negedge clk);
        end
        // Room for a stray output after the last expected one
        repeat (20) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: src/rgb_capture_top.sv
`timescale 1ns/100ps

`include "pix_macros.svh"

module rgb_capture_top (
    input  logic                clk,
    input  logic                nrst,
    input  pix_pkg::rgb_t       cam_rgb,
    input  logic                cam_hsync,
    input  logic                cam_vsync,
    input  logic                cam_strobe,
    input  logic                rgb_enable,
    output pix_pkg::rgb_t       pixel_data,
    output logic [31:0]         pixel_idx,
    output logic                pixel_valid,
    output logic                sum_valid,
    output pix_pkg::block_sum_t sum_value,
    output logic [2:0]          sum_block_col,
    output logic [1:0]          sum_block_line,
    output logic                overflow
);
    import pix_pkg::*;

    logic       push;
    fifo_word_t push_word;
    logic       full;
    logic       empty;
    rgb_t       fifo_rgb;
    logic       fifo_hsync;
    logic       fifo_vsync;
    logic [2:0] pixel_col;
    logic [3:0] pixel_line;
    logic [2:0] block_col;
    logic [1:0] block_line;

    cam_sampler cam_sampler_i (
        .clk        (clk),
        .nrst       (nrst),
        .cam_rgb    (cam_rgb),
        .cam_hsync  (cam_hsync),
        .cam_vsync  (cam_vsync),
        .cam_strobe (cam_strobe),
        .full       (full),
        .push       (push),
        .push_word  (push_word),
        .overflow   (overflow)
    );

    pixel_fifo #(
        .depth_log2 (`PIX_FIFO_DEPTH_LOG2)
    ) pixel_fifo_i (
        .clk       (clk),
        .nrst      (nrst),
        .push      (push),
        .push_word (push_word),
        .rgb       (fifo_rgb),
        .hsync     (fifo_hsync),
        .vsync     (fifo_vsync),
        .empty     (empty),
        .full      (full)
    );

    rgb_logic rgb_logic_i (
        .clk         (clk),
        .nrst        (nrst),
        .rgb         (fifo_rgb),
        .hsync       (fifo_hsync),
        .vsync       (fifo_vsync),
        .empty       (empty),
        .pixel_data  (pixel_data),
        .pixel_idx   (pixel_idx),
        .pixel_valid (pixel_valid),
        .pixel_col   (pixel_col),
        .pixel_line  (pixel_line),
        .block_col   (block_col),
        .block_line  (block_line),
        .rgb_enable  (rgb_enable)
    );

    block_stats block_stats_i (
        .clk            (clk),
        .nrst           (nrst),
        .pixel_data     (pixel_data),
        .pixel_valid    (pixel_valid),
        .pixel_idx      (pixel_idx),
        .pixel_col      (pixel_col),
        .pixel_line     (pixel_line),
        .block_col      (block_col),
        .block_line     (block_line),
        .sum_valid      (sum_valid),
        .sum_value      (sum_value),
        .sum_block_col  (sum_block_col),
        .sum_block_line (sum_block_line)
    );

endmodule

// File: src/block_stats.sv
`timescale 1ns/100ps

`include "pix_macros.svh"

module block_stats (
    input  logic                clk,
    input  logic                nrst,
    input  pix_pkg::rgb_t       pixel_data,
    input  logic                pixel_valid,
    input  logic [31:0]         pixel_idx,
    input  logic [2:0]          pixel_col,
    input  logic [3:0]          pixel_line,
    input  logic [2:0]          block_col,
    input  logic [1:0]          block_line,
    output logic                sum_valid,
    output pix_pkg::block_sum_t sum_value,
    output logic [2:0]          sum_block_col,
    output logic [1:0]          sum_block_line
);
    import pix_pkg::*;

    localparam logic [2:0] last_col = 3'(`PIX_BLOCK_W - 1);
    localparam logic [3:0] last_line = 4'(`PIX_BLOCK_H - 1);

    // Shown coordinates already point one pixel ahead
    logic [2:0] next_col;
    logic [3:0] next_line;
    logic [2:0] next_bcol;
    logic [1:0] next_bline;

    logic [2:0] cur_col;
    logic [3:0] cur_line;
    logic [2:0] cur_bcol;
    logic [1:0] cur_bline;
    logic       first_pixel;

    block_sum_t sums [`PIX_BLOCK_COLS];
    block_sum_t new_sum;

    // First pixel of a frame sits at the origin
    assign first_pixel = (pixel_idx == 32'd1);
    assign cur_col = first_pixel ? 3'd0 : next_col;
    assign cur_line = first_pixel ? 4'd0 : next_line;
    assign cur_bcol = first_pixel ? 3'd0 : next_bcol;
    assign cur_bline = first_pixel ? 2'd0 : next_bline;

    // First pixel of a block restarts its sum
    assign new_sum = (((cur_line == 4'd0) && (cur_col == 3'd0)) ? 15'd0 : sums[cur_bcol]) +
                     15'(pixel_data.green);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            next_col <= '0;
            next_line <= '0;
            next_bcol <= '0;
            next_bline <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= pixel_valid && (cur_col == last_col) && (cur_line == last_line);
            if (pixel_valid) begin
                next_col <= pixel_col;
                next_line <= pixel_line;
                next_bcol <= block_col;
                next_bline <= block_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            sums[cur_bcol] <= new_sum;
            sum_value <= new_sum;
            sum_block_col <= cur_bcol;
            sum_block_line <= cur_bline;
        end
    end

endmodule

// File: src/rgb_logic.sv
`timescale 1ns/100ps

module rgb_logic (
    input  logic        clk,
    input  logic        nrst,

    input  logic [23:0] rgb,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        empty,

    // Latched pixel
    output logic [23:0] pixel_data,
    output logic [31:0] pixel_idx,
    output logic        pixel_valid,

    // Position inside the micro-block
    output logic [2:0]  pixel_col,
    output logic [3:0]  pixel_line,
    // Micro-block position in the frame
    output logic [2:0]  block_col,
    output logic [1:0]  block_line,

    // Sampled once per frame at the frame start
    input  logic        rgb_enable
);

    logic vsync_r;
    logic frame_enable;
    logic sync_valid;
    logic frame_start;
    logic is_pixel;

    assign frame_start = ~vsync_r & vsync;
    assign is_pixel = vsync & hsync;

    // Pixel index within the frame
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            vsync_r <= 1'b0;
            pixel_idx <= '0;
        end else if (!empty) begin
            vsync_r <= vsync;
            if (frame_start) begin
                pixel_idx <= '0;
            end
            if (vsync_r && is_pixel) begin
                pixel_idx <= pixel_idx + 1'b1;
            end
        end
    end

    // Nested coordinate counters
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pixel_col <= '0;
            pixel_line <= '0;
            block_col <= '0;
            block_line <= '0;
            frame_enable <= 1'b0;
        end else if (!empty) begin
            if (frame_start) begin
                pixel_col <= '0;
                pixel_line <= '0;
                block_col <= '0;
                block_line <= '0;
                frame_enable <= rgb_enable;
            end else if (is_pixel) begin
                pixel_col <= pixel_col + 1'b1;
                if (pixel_col == 3'd7) begin
                    pixel_col <= '0;
                    block_col <= block_col + 1'b1;
                    // End of a frame line
                    if (block_col == 3'd4) begin
                        block_col <= '0;
                        pixel_line <= pixel_line + 1'b1;
                        if (pixel_line == 4'd15) begin
                            pixel_line <= '0;
                            block_line <= block_line + 1'b1;
                            if (block_line == 2'd3) begin
                                block_line <= '0;
                            end
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!empty) begin
            pixel_data <= rgb;
        end
    end

    // One cycle per popped pixel word
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sync_valid <= 1'b0;
        end else begin
            sync_valid <= ~empty & is_pixel;
        end
    end

    assign pixel_valid = frame_enable & sync_valid;

endmodule

// File: src/pixel_fifo.sv
`timescale 1ns/100ps

module pixel_fifo #(
    parameter int depth_log2 = 4
) (
    input  logic                clk,
    input  logic                nrst,
    input  logic                push,
    input  pix_pkg::fifo_word_t push_word,
    output pix_pkg::rgb_t       rgb,
    output logic                hsync,
    output logic                vsync,
    output logic                empty,
    output logic                full
);
    import pix_pkg::*;

    localparam int depth = 1 << depth_log2;

    fifo_word_t          mem [depth];
    logic [depth_log2:0] wr_ptr;
    logic [depth_log2:0] rd_ptr;
    logic                wr_en;
    logic                rd_en;
    fifo_word_t          head;

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[depth_log2] != rd_ptr[depth_log2]) &&
                  (wr_ptr[depth_log2-1:0] == rd_ptr[depth_log2-1:0]);

    assign wr_en = push & ~full;
    // The consumer takes the head on every cycle it is there
    assign rd_en = ~empty;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[depth_log2-1:0]] <= push_word;
        end
    end

    // Head word split into the fields rgb_logic reads
    assign head = mem[rd_ptr[depth_log2-1:0]];
    assign rgb = head.rgb;
    assign hsync = head.hsync;
    assign vsync = head.vsync;

endmodule

// File: src/cam_sampler.sv
`timescale 1ns/100ps

module cam_sampler (
    input  logic               clk,
    input  logic               nrst,
    input  pix_pkg::rgb_t      cam_rgb,
    input  logic               cam_hsync,
    input  logic               cam_vsync,
    input  logic               cam_strobe,
    input  logic               full,
    output logic               push,
    output pix_pkg::fifo_word_t push_word,
    output logic               overflow
);
    import pix_pkg::*;

    sampler_state_e state;
    logic           vsync_prev;
    logic           frame_start;
    logic           pending;

    // First strobed word with vsync high after a word with vsync low
    assign frame_start = cam_strobe && cam_vsync && !vsync_prev && (state == WAIT_FRAME);

    // Word is lost if the FIFO is full when it is due
    assign push = pending & ~full;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= WAIT_FRAME;
            // Assume a frame is running, so the partial one is dropped
            vsync_prev <= 1'b1;
            pending <= 1'b0;
            overflow <= 1'b0;
        end else begin
            pending <= cam_strobe && ((state == IN_FRAME) || frame_start);
            if (cam_strobe) begin
                vsync_prev <= cam_vsync;
            end
            if (frame_start) begin
                state <= IN_FRAME;
            end
            // Sticky until reset
            if (pending && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cam_strobe) begin
            push_word.rgb <= cam_rgb;
            push_word.hsync <= cam_hsync;
            push_word.vsync <= cam_vsync;
        end
    end

endmodule

// File: src/pix_pkg.sv
package pix_pkg;

    // One camera pixel, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // FIFO entry, vsync sits in the top bit
    typedef struct packed {
        logic vsync;
        logic hsync;
        rgb_t rgb;
    } fifo_word_t;

    // Sum of 128 green bytes, 255 * 128 fits in 15 bits
    typedef logic [14:0] block_sum_t;

    // Sampler waits for a clean frame start before pushing
    typedef enum logic {
        WAIT_FRAME,
        IN_FRAME
    } sampler_state_e;

endpackage

// File: src/pix_macros.svh
`ifndef PIX_MACROS_SVH
`define PIX_MACROS_SVH

// Micro-block size in pixels and lines
`define PIX_BLOCK_W 8
`define PIX_BLOCK_H 16

// Blocks per frame, 40 x 64 pixels in total
`define PIX_BLOCK_COLS 5
`define PIX_BLOCK_LINES 4

// Default pixel FIFO of 16 entries
`define PIX_FIFO_DEPTH_LOG2 4

`endif
